// ==== logic/alu_macros.svh ====
// Width and register-count constants for the execute subsystem
// Shared by both packages and the datapath modules

`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// Datapath word, one register or one immediate
`define OPERAND_WIDTH 16

// Architectural register file
`define REG_COUNT 8

// Bits needed to name one register
`define REG_INDEX_WIDTH 3

`endif

// ==== logic/isaPkg.sv ====
// Instruction-set types for the execute subsystem
// Opcode enum and the decoded operation passed from issue to the ALU

`include "alu_macros.svh"

package isaPkg;

    // Instruction word layout, 16 bits
    //   [15:12] opcode
    //   [11:9]  rd, destination
    //   [8:6]   rs, operand A (register forms)
    //   [5:3]   rt, operand B (register forms)
    //   [7:0]   immediate, zero-extended into operand B (LBI, SLBI)
    // LBI and SLBI read rd as operand A

    // Encoding order matters, shifter mode is opcode[1:0]
    typedef enum logic [3:0] {
        ROL  = 4'b0000, // Rotate left
        SLL  = 4'b0001, // Shift left logical
        ROR  = 4'b0010, // Rotate right
        SRL  = 4'b0011, // Shift right logical
        ADD  = 4'b0100, // A + B
        SUB  = 4'b0101, // B - A
        XOR  = 4'b0110,
        ANDN = 4'b0111, // A & ~B
        SEQ  = 4'b1000, // Set if A == B
        SLT  = 4'b1001, // Set if A < B, signed
        SLE  = 4'b1010, // Set if A <= B, signed
        RSVD = 4'b1011, // Reserved, dropped at issue
        SCO  = 4'b1100, // Set on carry out of A + B
        LBI  = 4'b1101, // Load immediate
        BTR  = 4'b1110, // Bit reverse of A
        SLBI = 4'b1111  // (A << 8) | imm
    } aluOp;

    // Operation leaving issue, operands already read
    typedef struct packed {
        aluOp                        op;
        logic [`REG_INDEX_WIDTH-1:0] dest;  // rd
        logic [`REG_INDEX_WIDTH-1:0] srcA;  // Register behind aVal
        logic [`REG_INDEX_WIDTH-1:0] srcB;  // Register behind bVal, unused if bImm
        logic                        bImm;  // bVal holds the immediate
        logic [`OPERAND_WIDTH-1:0]   aVal;
        logic [`OPERAND_WIDTH-1:0]   bVal;
        logic                        valid;
    } issueOp;

endpackage

// ==== logic/aluPkg.sv ====
// Datapath types for the execute subsystem
// Condition flags and the registered ALU result

`include "alu_macros.svh"

package aluPkg;

    // Condition flags produced with every result
    // zero and sign follow the final data value
    // carry and overflow come straight from the adder,
    // meaningful only for ADD and SUB
    typedef struct packed {
        logic zero;     // Data is all zeros
        logic sign;     // Data MSB
        logic overflow; // Signed overflow of the add
        logic carry;    // Carry out of the add
    } aluFlags;

    // One finished operation
    // Feeds writeback, forwarding and the core outputs alike
    typedef struct packed {
        logic [`OPERAND_WIDTH-1:0]   data;
        logic [`REG_INDEX_WIDTH-1:0] dest;  // Register to write
        aluFlags                     flags;
        logic                        valid; // One-cycle strobe
    } aluResult;

endpackage

// ==== logic/operandIssue.sv ====
// Issue stage: decodes instruction words and reads operands
// Owns the register file, written back from the ALU result

`include "alu_macros.svh"

module operandIssue import isaPkg::*, aluPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        instValid,  // One word this cycle
    input  logic [15:0] instWord,
    input  aluResult    wbResult,   // Writeback from ALU result register
    output issueOp      issue       // Combinational, same cycle as instValid
);

    logic [`OPERAND_WIDTH-1:0]   regFile [`REG_COUNT];

    aluOp                        opc;
    logic [`REG_INDEX_WIDTH-1:0] rd;
    logic [`REG_INDEX_WIDTH-1:0] rs;
    logic [`REG_INDEX_WIDTH-1:0] rt;
    logic [7:0]                  imm;
    logic                        immForm;   // LBI / SLBI
    logic [`REG_INDEX_WIDTH-1:0] srcA;
    logic [`REG_INDEX_WIDTH-1:0] srcB;
    logic [`OPERAND_WIDTH-1:0]   aRead;
    logic [`OPERAND_WIDTH-1:0]   bRead;

    // Field split
    assign opc = aluOp'(instWord[15:12]);
    assign rd  = instWord[11:9];
    assign rs  = instWord[8:6];
    assign rt  = instWord[5:3];
    assign imm = instWord[7:0];

    assign immForm = (opc == LBI) || (opc == SLBI);

    // Immediate forms operate on rd itself
    assign srcA = immForm ? rd : rs;
    assign srcB = immForm ? '0 : rt;

    // Asynchronous read, same-cycle write bypassed
    always_comb begin
        aRead = regFile[srcA];
        if (wbResult.valid && (wbResult.dest == srcA)) begin
            aRead = wbResult.data;   // Value landing this edge
        end
    end

    always_comb begin
        bRead = regFile[srcB];
        if (wbResult.valid && (wbResult.dest == srcB)) begin
            bRead = wbResult.data;
        end
    end

    // Writeback port
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regFile[i] <= '0;   // All registers read zero after reset
            end
        end else if (wbResult.valid) begin
            regFile[wbResult.dest] <= wbResult.data;
        end
    end

    // Decoded operation
    always_comb begin
        issue.op    = opc;
        issue.dest  = rd;
        issue.srcA  = srcA;
        issue.srcB  = srcB;
        issue.bImm  = immForm;
        issue.aVal  = aRead;
        // Immediate is zero-extended into B
        issue.bVal  = immForm ? {{(`OPERAND_WIDTH-8){1'b0}}, imm} : bRead;
        issue.valid = instValid && (opc != RSVD);   // Reserved word dies here
    end

    // Writeback must name a known register
    wbDestKnown: assert property (
        @(posedge clk) disable iff (!rstN)
        wbResult.valid |-> !$isunknown(wbResult.dest)
    );

endmodule

// ==== logic/execLatch.sv ====
// Latch stage between issue and ALU
// Holds one operation and forwards the result still in flight

`include "alu_macros.svh"

module execLatch import isaPkg::*, aluPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  issueOp   issueIn,    // From issue, captured each edge
    input  aluResult fwdResult,  // ALU result register, not yet written back
    output issueOp   issueOut    // Held op with forwarded operands
);

    logic   heldValid;
    issueOp heldOp;   // Payload only, valid bit kept in heldValid

    logic   fwdHitA;
    logic   fwdHitB;

    // Control flop
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            heldValid <= 1'b0;
        end else begin
            heldValid <= issueIn.valid;
        end
    end

    // Payload, loads only with a real operation
    always_ff @(posedge clk) begin
        if (issueIn.valid) begin
            heldOp <= issueIn;
        end
    end

    // The result register holds the op one slot ahead of us
    // Its value was read too early by issue, so patch it in here
    assign fwdHitA = fwdResult.valid && (fwdResult.dest == heldOp.srcA);
    assign fwdHitB = fwdResult.valid && !heldOp.bImm     // Immediates stay
                     && (fwdResult.dest == heldOp.srcB);

    always_comb begin
        issueOut       = heldOp;
        issueOut.valid = heldValid;
        if (fwdHitA) begin
            issueOut.aVal = fwdResult.data;
        end
        if (fwdHitB) begin
            issueOut.bVal = fwdResult.data;
        end
    end

    // First edge after reset release sees an empty stage
    emptyAfterReset: assert property (
        @(posedge clk)
        $rose(rstN) |-> !issueOut.valid
    );

endmodule

// ==== logic/alu.sv ====
// ALU stage: shifter, adder, logic unit and compare
// Selects by opcode, builds flags, registers the result

`include "alu_macros.svh"

module alu import isaPkg::*, aluPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  issueOp   op,      // Latched op, operands forwarded
    output aluResult result   // Registered, one edge after op
);

    localparam int W = `OPERAND_WIDTH;

    logic                        subLike;   // B - A through the adder
    logic [W-1:0]                aInt;
    logic [W-1:0]                bInt;
    logic                        cin;

    logic [3:0]                  shAmt;
    logic [1:0]                  shMode;
    logic [2*W-1:0]              twice;     // A twice, for rotates
    logic [W-1:0]                shiftOut;

    logic [W-1:0]                sum;
    logic                        carry;
    logic                        ovf;
    logic                        sumZero;
    logic                        bLessA;    // Signed, from B - A

    logic [W-1:0]                xorOut;
    logic [W-1:0]                andnOut;
    logic [W-1:0]                revA;
    logic [W-1:0]                dataNext;
    aluFlags                     flagsNext;

    logic [W-1:0]                dataQ;
    logic [`REG_INDEX_WIDTH-1:0] destQ;
    aluFlags                     flagsQ;
    logic                        validQ;

    // Operand conditioning
    assign subLike = op.op inside {SUB, SEQ, SLT, SLE};
    assign aInt    = subLike ? ~op.aVal : op.aVal;   // Two's complement with cin
    assign cin     = subLike;
    assign bInt    = (op.op == ANDN) ? ~op.bVal : op.bVal;

    // Barrel shifter, SLBI borrows it as a fixed shift left by 8
    assign shAmt  = (op.op == SLBI) ? 4'd8 : op.bVal[3:0];
    assign shMode = (op.op == SLBI) ? 2'b01 : op.op[1:0];
    assign twice  = {op.aVal, op.aVal};

    always_comb begin
        unique case (shMode)
            2'b00:   shiftOut = twice[2*W-1-shAmt -: W];   // ROL
            2'b01:   shiftOut = op.aVal << shAmt;          // SLL
            2'b10:   shiftOut = twice[shAmt +: W];         // ROR
            default: shiftOut = op.aVal >> shAmt;          // SRL
        endcase
    end

    // Adder
    assign {carry, sum} = {1'b0, aInt} + {1'b0, bInt} + {{W{1'b0}}, cin};

    // Same-sign inputs, different-sign sum
    assign ovf = (aInt[W-1] == bInt[W-1]) && (sum[W-1] != aInt[W-1]);

    // Compares ride on B - A
    assign sumZero = (sum == '0);
    assign bLessA  = sum[W-1] ^ ovf;   // True sign of B - A

    // Bitwise units
    assign xorOut  = aInt ^ bInt;
    assign andnOut = aInt & bInt;     // bInt already inverted

    always_comb begin
        for (int i = 0; i < W; i++) begin
            revA[i] = op.aVal[W-1-i];
        end
    end

    // Result select
    always_comb begin
        unique case (op.op)
            ROL, SLL, ROR, SRL: dataNext = shiftOut;
            ADD, SUB:           dataNext = sum;
            XOR:                dataNext = xorOut;
            ANDN:               dataNext = andnOut;
            SEQ:                dataNext = {{(W-1){1'b0}}, sumZero};
            SLT:                dataNext = {{(W-1){1'b0}}, !bLessA && !sumZero};
            SLE:                dataNext = {{(W-1){1'b0}}, !bLessA};
            SCO:                dataNext = {{(W-1){1'b0}}, carry};
            LBI:                dataNext = op.bVal;
            BTR:                dataNext = revA;
            SLBI:               dataNext = shiftOut | op.bVal;
            default:            dataNext = '0;   // RSVD never issued
        endcase
    end

    // Flags
    assign flagsNext.zero     = (dataNext == '0);
    assign flagsNext.sign     = dataNext[W-1];
    assign flagsNext.overflow = ovf;
    assign flagsNext.carry    = carry;

    // Result register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= op.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (op.valid) begin
            dataQ  <= dataNext;
            destQ  <= op.dest;
            flagsQ <= flagsNext;
        end
    end

    assign result = '{data: dataQ, dest: destQ, flags: flagsQ, valid: validQ};

    // Zero after SUB only when the operands were equal
    subZeroOnEqual: assert property (
        @(posedge clk) disable iff (!rstN)
        (op.valid && op.op == SUB) |=>
            (result.flags.zero == ($past(op.aVal) == $past(op.bVal)))
    );

endmodule

// ==== logic/aluCore.sv ====
// Execute subsystem top: issue, latch and ALU in a ring
// Fixed two-edge latency from instruction to result

`include "alu_macros.svh"

module aluCore import isaPkg::*, aluPkg::*; (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        instValid,
    input  logic [15:0]                 instWord,
    output logic                        resValid,
    output logic [`OPERAND_WIDTH-1:0]   resData,
    output logic [`REG_INDEX_WIDTH-1:0] resDest,
    output aluFlags                     resFlags
);

    issueOp   issued;    // Issue -> latch
    issueOp   latched;   // Latch -> ALU
    aluResult result;    // ALU -> writeback, forwarding, outputs

    operandIssue issue_i (
        .clk       (clk),
        .rstN      (rstN),
        .instValid (instValid),
        .instWord  (instWord),
        .wbResult  (result),
        .issue     (issued)
    );

    execLatch latch_i (
        .clk       (clk),
        .rstN      (rstN),
        .issueIn   (issued),
        .fwdResult (result),
        .issueOut  (latched)
    );

    alu alu_i (
        .clk    (clk),
        .rstN   (rstN),
        .op     (latched),
        .result (result)
    );

    // Core outputs straight from the result register
    assign resValid = result.valid;
    assign resData  = result.data;
    assign resDest  = result.dest;
    assign resFlags = result.flags;

endmodule

// ==== verification/aluChecker.sv ====
// Reference model and scoreboard for the execute core
// Predicts each result at issue time and compares it at the output ports

`include "alu_macros.svh"

module aluChecker import isaPkg::*, aluPkg::*; (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        instValid,
    input  logic [15:0]                 instWord,
    input  logic                        resValid,
    input  logic [`OPERAND_WIDTH-1:0]   resData,
    input  logic [`REG_INDEX_WIDTH-1:0] resDest,
    input  aluFlags                     resFlags,
    output int                          errorCount,
    output int                          checkCount,
    output int                          pending     // Results still owed by the DUT
);

    localparam int W = `OPERAND_WIDTH;

    typedef struct packed {
        logic [W-1:0]                data;
        logic [`REG_INDEX_WIDTH-1:0] dest;
        aluFlags                     flags;
        logic                        arith;  // Carry and overflow defined
        logic [31:0]                 due;    // Cycle the result must show up
        logic [15:0]                 word;   // Source instruction, for messages
    } expectedRes;

    logic [W-1:0] modelRegs [`REG_COUNT];
    expectedRes   expQ [$];
    int unsigned  cycle;

    initial begin
        errorCount = 0;
        checkCount = 0;
        pending    = 0;
    end

    // Result of one instruction, straight from the ISA rules
    function automatic expectedRes predict(logic [15:0] word);
        expectedRes e;
        aluOp       op;
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic [W:0]   wide;
        logic [W:0]   sWide;
        logic [3:0]   amt;
        op     = aluOp'(word[15:12]);
        e      = '0;
        e.word = word;
        e.dest = word[11:9];
        if (op == LBI || op == SLBI) begin
            a = modelRegs[word[11:9]];          // Immediate forms read rd
            b = {{(W-8){1'b0}}, word[7:0]};
        end else begin
            a = modelRegs[word[8:6]];
            b = modelRegs[word[5:3]];
        end
        amt = b[3:0];
        case (op)
            ROL:  e.data = (a << amt) | (a >> (W - amt));
            SLL:  e.data = a << amt;
            ROR:  e.data = (a >> amt) | (a << (W - amt));
            SRL:  e.data = a >> amt;
            ADD: begin
                wide             = {1'b0, a} + {1'b0, b};
                sWide            = {a[W-1], a} + {b[W-1], b};   // Sign-extended sum
                e.data           = wide[W-1:0];
                e.flags.carry    = wide[W];
                e.flags.overflow = (sWide[W] != sWide[W-1]);    // Out of signed range
            end
            SUB: begin
                wide             = {1'b0, b} + {1'b0, ~a} + 1'b1;   // B minus A
                e.data           = wide[W-1:0];
                e.flags.carry    = wide[W];
                e.flags.overflow = (a[W-1] != b[W-1]) && (wide[W-1] != b[W-1]);
            end
            XOR:  e.data = a ^ b;
            ANDN: e.data = a & ~b;
            SEQ:  e.data = (a == b) ? 1 : 0;
            SLT:  e.data = ($signed(a) < $signed(b)) ? 1 : 0;
            SLE:  e.data = ($signed(a) <= $signed(b)) ? 1 : 0;
            SCO: begin
                wide   = {1'b0, a} + {1'b0, b};
                e.data = {{(W-1){1'b0}}, wide[W]};
            end
            LBI:  e.data = b;
            BTR: begin
                for (int i = 0; i < W; i++) begin
                    e.data[i] = a[W-1-i];
                end
            end
            SLBI: e.data = (a << 8) | b;
            default: e.data = '0;   // RSVD, never queued
        endcase
        e.flags.zero = (e.data == '0);
        e.flags.sign = e.data[W-1];
        e.arith      = (op == ADD) || (op == SUB);
        return e;
    endfunction

    task automatic compareField(string name, logic [15:0] got, logic [15:0] want,
                                logic [15:0] word);
        if (got !== want) begin
            errorCount++;
            $display("MISMATCH %s: got 0x%h expected 0x%h (instruction 0x%h)",
                     name, got, want, word);
        end
    endtask

    task automatic checkResult(expectedRes e);
        checkCount++;
        if (e.due != cycle) begin
            errorCount++;
            $display("Result for instruction 0x%h came at cycle %0d instead of %0d",
                     e.word, cycle, e.due);
        end
        compareField("resData", resData, e.data, e.word);
        compareField("resDest", 16'(resDest), 16'(e.dest), e.word);
        compareField("resFlags.zero", 16'(resFlags.zero), 16'(e.flags.zero), e.word);
        compareField("resFlags.sign", 16'(resFlags.sign), 16'(e.flags.sign), e.word);
        if (e.arith) begin   // Adder flags only for ADD and SUB
            compareField("resFlags.carry", 16'(resFlags.carry), 16'(e.flags.carry), e.word);
            compareField("resFlags.overflow", 16'(resFlags.overflow),
                         16'(e.flags.overflow), e.word);
        end
    endtask

    // Pre-edge values of all DUT ports and stimulus
    always @(posedge clk) begin
        expectedRes e;
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                modelRegs[i] = '0;
            end
            expQ.delete();
            cycle = 0;
            if (resValid) begin
                errorCount++;
                $display("resValid was high while reset was asserted");
            end
        end else begin
            cycle++;
            if (resValid) begin
                if (expQ.size() == 0) begin
                    errorCount++;
                    $display("Result for r%0d at cycle %0d with no instruction outstanding",
                             resDest, cycle);
                end else begin
                    e = expQ.pop_front();
                    checkResult(e);
                end
            end else if (expQ.size() != 0 && expQ[0].due <= cycle) begin
                e = expQ.pop_front();
                errorCount++;
                $display("No result for instruction 0x%h, it was due at cycle %0d",
                         e.word, e.due);
            end
            if (instValid && instWord[15:12] != RSVD) begin
                e     = predict(instWord);
                e.due = cycle + 2;                // Two edges of latency
                expQ.push_back(e);
                modelRegs[e.dest] = e.data;       // In order, so forwarding is implied
            end
        end
        pending = expQ.size();
    end

endmodule

// ==== verification/aluCoreTb.sv ====
// Testbench for the execute core with a seeded random instruction stream
// Six tests, a scoreboard module and a watchdog

`include "alu_macros.svh"

module aluCoreTb import isaPkg::*, aluPkg::*; ();

    localparam int RESET_CYCLES  = 5;
    localparam int IMM_COUNT     = 2 * `REG_COUNT;   // LBI + SLBI per register
    localparam int ARITH_COUNT   = 64;
    localparam int CMP_RANDOM    = 40;
    localparam int CMP_COUNT     = CMP_RANDOM + 14;  // Plus the fixed boundary set
    localparam int CHAIN_COUNT   = 32;
    localparam int GAP_COUNT     = 40;
    localparam int TEST_COUNT    = 6;
    localparam int TOTAL_SLOTS   = RESET_CYCLES + 2 + IMM_COUNT + ARITH_COUNT + CMP_COUNT
                                   + CHAIN_COUNT + GAP_COUNT + TEST_COUNT * 8;
    localparam int WATCHDOG_TIME = TOTAL_SLOTS * 8 + 400;

    logic                        clk;
    logic                        rstN;
    logic                        instValid;
    logic [15:0]                 instWord;
    logic                        resValid;
    logic [`OPERAND_WIDTH-1:0]   resData;
    logic [`REG_INDEX_WIDTH-1:0] resDest;
    aluFlags                     resFlags;
    int                          errorCount;
    int                          checkCount;
    int                          pending;
    int                          errStart;
    int                          chkStart;
    int                          testsOk;
    int                          testsBad;

    aluCore dut_i (
        .clk       (clk),
        .rstN      (rstN),
        .instValid (instValid),
        .instWord  (instWord),
        .resValid  (resValid),
        .resData   (resData),
        .resDest   (resDest),
        .resFlags  (resFlags)
    );

    aluChecker checker_i (
        .clk        (clk),
        .rstN       (rstN),
        .instValid  (instValid),
        .instWord   (instWord),
        .resValid   (resValid),
        .resData    (resData),
        .resDest    (resDest),
        .resFlags   (resFlags),
        .errorCount (errorCount),
        .checkCount (checkCount),
        .pending    (pending)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;   // Period 8

    function automatic logic [15:0] regWord(aluOp op, logic [2:0] rd, logic [2:0] rs,
                                            logic [2:0] rt);
        return {op, rd, rs, rt, 3'b000};
    endfunction

    function automatic logic [15:0] immWord(aluOp op, logic [2:0] rd, logic [7:0] imm);
        return {op, rd, 1'b0, imm};
    endfunction

    // Shifts, add/sub, logic ops and BTR
    function automatic aluOp randomArithOp();
        int pick;
        pick = $urandom_range(8);
        return (pick == 8) ? BTR : aluOp'(pick[3:0]);
    endfunction

    task automatic sendWord(logic [15:0] word);
        @(posedge clk);
        instValid <= 1'b1;
        instWord  <= word;
    endtask

    task automatic idleCycle();
        @(posedge clk);
        instValid <= 1'b0;
        instWord  <= 16'($urandom);   // Junk, must be ignored
    endtask

    // Drain the pipe, then one summary line for the test
    task automatic reportTest(string name);
        int errs;
        int chks;
        idleCycle();
        do @(negedge clk); while (pending != 0);
        repeat (2) @(negedge clk);   // Room for a stray pulse within the fixed latency
        errs = errorCount - errStart;
        chks = checkCount - chkStart;
        if (errs == 0) testsOk++;
        else testsBad++;
        $display("%s %s: %0d results checked, %0d errors",
                 (errs == 0) ? "ok  " : "FAIL", name, chks, errs);
        errStart = errorCount;
        chkStart = checkCount;
    endtask

    task automatic checkResetState();
        sendWord(regWord(ADD, 3'd1, 3'd2, 3'd3));   // Both sources still zero
        sendWord(regWord(ADD, 3'd0, 3'd0, 3'd0));
        reportTest("reset state");
    endtask

    task automatic loadImmediates();
        for (int r = 0; r < `REG_COUNT; r++) begin
            sendWord(immWord(LBI, 3'(r), 8'($urandom)));
            sendWord(immWord(SLBI, 3'(r), 8'($urandom)));   // Pulls LBI value into high byte
        end
        reportTest("immediate loads");
    endtask

    task automatic runArithmetic();
        for (int i = 0; i < ARITH_COUNT; i++) begin
            if (i % 8 == 7) begin   // Keep register contents from decaying to zero
                sendWord(immWord(SLBI, 3'($urandom), 8'($urandom)));
            end else begin
                sendWord(regWord(randomArithOp(), 3'($urandom), 3'($urandom), 3'($urandom)));
            end
        end
        reportTest("random arithmetic and logic");
    endtask

    task automatic runComparisons();
        int pick;
        sendWord(immWord(LBI, 3'd1, 8'h80));    // r1 = 0x8000
        sendWord(immWord(SLBI, 3'd1, 8'h00));
        sendWord(immWord(LBI, 3'd2, 8'h7f));    // r2 = 0x7fff
        sendWord(immWord(SLBI, 3'd2, 8'hff));
        sendWord(immWord(LBI, 3'd3, 8'hff));    // r3 = 0xffff
        sendWord(immWord(SLBI, 3'd3, 8'hff));
        sendWord(regWord(SEQ, 3'd4, 3'd2, 3'd2));
        sendWord(regWord(SLE, 3'd4, 3'd1, 3'd1));
        sendWord(regWord(SLT, 3'd4, 3'd1, 3'd2));   // Most negative vs most positive
        sendWord(regWord(SLT, 3'd4, 3'd2, 3'd1));
        sendWord(regWord(SLE, 3'd4, 3'd3, 3'd2));
        sendWord(regWord(SLT, 3'd4, 3'd1, 3'd1));   // Equal is not less
        sendWord(regWord(SCO, 3'd4, 3'd1, 3'd1));   // Carries out
        sendWord(regWord(SCO, 3'd4, 3'd2, 3'd2));
        for (int i = 0; i < CMP_RANDOM; i++) begin
            pick = $urandom_range(3);
            sendWord(regWord((pick == 3) ? SCO : aluOp'(4'(8 + pick)),
                             3'(4 + $urandom_range(3)), 3'($urandom), 3'($urandom)));
        end
        reportTest("comparisons");
    endtask

    task automatic chainDependencies();
        logic [2:0] prev;
        logic [2:0] next;
        prev = 3'($urandom);
        sendWord(immWord(LBI, prev, 8'($urandom)));
        for (int i = 1; i < CHAIN_COUNT; i++) begin
            next = 3'($urandom);
            if (i % 2 == 1) begin   // Alternate which operand needs the forward
                sendWord(regWord(randomArithOp(), next, prev, 3'($urandom)));
            end else begin
                sendWord(regWord(randomArithOp(), next, 3'($urandom), prev));
            end
            prev = next;
        end
        reportTest("back-to-back dependencies");
    endtask

    task automatic mixReservedAndGaps();
        int pick;
        for (int i = 0; i < GAP_COUNT; i++) begin
            pick = $urandom_range(3);
            if (pick == 0) begin
                sendWord({RSVD, 12'($urandom)});   // Dropped at issue
            end else if (pick == 1) begin
                idleCycle();
            end else begin
                sendWord(regWord(randomArithOp(), 3'($urandom), 3'($urandom), 3'($urandom)));
            end
        end
        reportTest("reserved opcode and gaps");
    endtask

    initial begin
        void'($urandom(82));
        rstN      = 1'b0;
        instValid = 1'b0;
        instWord  = '0;
        errStart  = 0;
        chkStart  = 0;
        testsOk   = 0;
        testsBad  = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
        checkResetState();
        loadImmediates();
        runArithmetic();
        runComparisons();
        chainDependencies();
        mixReservedAndGaps();
        $display("Tests: %0d ok, %0d failing; results checked: %0d, errors: %0d",
                 testsOk, testsBad, checkCount, errorCount);
        if (checkCount == 0) begin
            $display("No results were checked at all");
        end
        if (testsBad == 0 && errorCount == 0 && checkCount > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog sized from the slot budget above
    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: run did not finish within %0d time units", WATCHDOG_TIME);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== Bender.yml ====
package:
  name: alu_core

export_include_dirs:
  - logic

sources:
  # Packages first, then the datapath bottom-up
  - include_dirs:
      - logic
    files:
      - logic/isaPkg.sv
      - logic/aluPkg.sv
      - logic/operandIssue.sv
      - logic/execLatch.sv
      - logic/alu.sv
      - logic/aluCore.sv

  # Testbench, checker before the top that instantiates it
  - target: test
    include_dirs:
      - logic
    files:
      - verification/aluChecker.sv
      - verification/aluCoreTb.sv

// ==== sources.f ====
+incdir+logic
logic/isaPkg.sv
logic/aluPkg.sv
logic/operandIssue.sv
logic/execLatch.sv
logic/alu.sv
logic/aluCore.sv
verification/aluChecker.sv
verification/aluCoreTb.sv
